// ==== verif/core_shell_testdata.txt ====
# R reset check | W busy dbg irq nm sleep_now sleep_next | A waddr wdata | Q hold_cycles
# E raddr_a exp_a raddr_b exp_b | K key nonce | X key nonce exp_req exp_valid  (hex values)
R
W 1 0 0 0 1 0
A 05 deadbeef
E 05 deadbeef 05 deadbeef
A 00 12345678
E 00 00000000 05 deadbeef
A 1f cafef00d
E 1f cafef00d 00 00000000
# Drop busy, then a write strobe while asleep
W 0 0 0 0 0 1
A 05 11111111
W 0 1 0 0 0 0
E 05 deadbeef 05 deadbeef
W 0 0 0 0 1 1
W 0 0 0 1 0 0
A 07 0badf00d
E 07 0badf00d 05 deadbeef
W 0 0 0 0 1 1
W 0 0 1 0 0 0
W 0 0 0 0 1 1
# Key request, held open before the provider answers
Q 3
X 0d6f3a81c2e497b55e108c7af3b24d69 f7a3196c2be8d054 1 0
K 00112233445566778899aabbccddeeff 0123456789abcdef
X 00112233445566778899aabbccddeeff 0123456789abcdef 0 1
# Unrequested key strobe
K ffeeddccbbaa99887766554433221100 fedcba9876543210
X ffeeddccbbaa99887766554433221100 fedcba9876543210 0 1
E 00 00000000 1f cafef00d

// ==== project.f ====
hdl/core_shell_pkg.sv
hdl/core_sleep_ctrl.sv
hdl/scramble_key_ctrl.sv
hdl/core_regfile_ff.sv
hdl/core_shell_top.sv
verif/core_shell_asserts.sv
verif/tb_core_shell.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core shell testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_core_shell \
  -f project.f \
  -o sim_core_shell
./obj_dir/sim_core_shell > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
grep -q "TEST RESULT: PASS" sim.log

// ==== verif/tb_core_shell.sv ====
/*
 * Core shell testbench
 * Replays the command file against the DUT and checks every response
 */
module tb_core_shell;

  localparam int    ReqTimeout = 16;
  localparam string DataFile   = "verif/core_shell_testdata.txt";

  logic clk_i;
  logic rst_ni;
  logic test_en_i;
  logic core_busy_i;
  logic debug_req_i;
  logic irq_pending_i;
  logic irq_nm_i;
  logic core_sleep_o;
  core_shell_pkg::reg_addr_t  rf_raddr_a_i;
  core_shell_pkg::reg_addr_t  rf_raddr_b_i;
  core_shell_pkg::reg_data_t  rf_rdata_a_o;
  core_shell_pkg::reg_data_t  rf_rdata_b_o;
  core_shell_pkg::reg_addr_t  rf_waddr_i;
  core_shell_pkg::reg_data_t  rf_wdata_i;
  logic                       rf_we_i;
  logic                       ic_scr_key_req_i;
  logic                       scramble_key_valid_i;
  core_shell_pkg::scr_key_t   scramble_key_i;
  core_shell_pkg::scr_nonce_t scramble_nonce_i;
  logic                       scramble_req_o;
  logic                       scr_key_valid_o;
  core_shell_pkg::scr_key_t   scr_key_o;
  core_shell_pkg::scr_nonce_t scr_nonce_o;

  core_shell_top core_shell_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Overall cycle limit
  initial begin
    repeat (400) @(posedge clk_i);
    abort_run("Simulation ran past its cycle limit");
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %b got %b", $time, name, exp, act);
      abort_run("Output differs from the expected value");
    end
  endtask

  task automatic check_data(input string name, input core_shell_pkg::reg_data_t act,
                            input core_shell_pkg::reg_data_t exp);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
      abort_run("Register read differs from the expected value");
    end
  endtask

  task automatic check_key(input string name, input core_shell_pkg::scr_key_t act,
                           input core_shell_pkg::scr_key_t exp);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
      abort_run("Scramble key differs from the expected value");
    end
  endtask

  task automatic check_nonce(input string name, input core_shell_pkg::scr_nonce_t act,
                             input core_shell_pkg::scr_nonce_t exp);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
      abort_run("Scramble nonce differs from the expected value");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Commands
  ////////////////////////////////////////////////////////////

  // Inputs change 10 units after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #10;
  endtask

  task automatic reset_check();
    #5;
    check_bit("core_sleep_o", core_sleep_o, 1'b1);
    check_bit("scramble_req_o", scramble_req_o, 1'b0);
    check_bit("scr_key_valid_o", scr_key_valid_o, 1'b1);
    check_key("scr_key_o", scr_key_o, core_shell_pkg::RndCnstKeyDefault);
    check_nonce("scr_nonce_o", scr_nonce_o, core_shell_pkg::RndCnstNonceDefault);
    for (int a = 0; a < 32; a++) begin
      rf_raddr_a_i = core_shell_pkg::reg_addr_t'(a);
      rf_raddr_b_i = core_shell_pkg::reg_addr_t'(31 - a);
      #1;
      check_data("rf_rdata_a_o", rf_rdata_a_o, '0);
      check_data("rf_rdata_b_o", rf_rdata_b_o, '0);
    end
    next_cycle();
  endtask

  // Sleep is checked in the drive cycle and again after one edge
  task automatic set_wake(input logic b, input logic d, input logic p, input logic n,
                          input logic sleep_now, input logic sleep_next);
    core_busy_i   = b;
    debug_req_i   = d;
    irq_pending_i = p;
    irq_nm_i      = n;
    #5;
    check_bit("core_sleep_o", core_sleep_o, sleep_now);
    next_cycle();
    #5;
    check_bit("core_sleep_o", core_sleep_o, sleep_next);
    next_cycle();
  endtask

  task automatic write_reg(input core_shell_pkg::reg_addr_t addr,
                           input core_shell_pkg::reg_data_t data);
    rf_waddr_i = addr;
    rf_wdata_i = data;
    rf_we_i    = 1'b1;
    next_cycle();
    rf_we_i    = 1'b0;
  endtask

  task automatic read_expect(input core_shell_pkg::reg_addr_t ra,
                             input core_shell_pkg::reg_data_t ea,
                             input core_shell_pkg::reg_addr_t rb,
                             input core_shell_pkg::reg_data_t eb);
    rf_raddr_a_i = ra;
    rf_raddr_b_i = rb;
    #5;
    check_data("rf_rdata_a_o", rf_rdata_a_o, ea);
    check_data("rf_rdata_b_o", rf_rdata_b_o, eb);
    next_cycle();
  endtask

  task automatic key_request(input int hold);
    ic_scr_key_req_i = 1'b1;
    next_cycle();
    ic_scr_key_req_i = 1'b0;
    for (int i = 0; i <= hold; i++) begin
      #5;
      check_bit("scramble_req_o", scramble_req_o, 1'b1);
      check_bit("scr_key_valid_o", scr_key_valid_o, 1'b0);
      next_cycle();
    end
  endtask

  task automatic key_supply(input core_shell_pkg::scr_key_t key,
                            input core_shell_pkg::scr_nonce_t nonce);
    int cycles;
    cycles               = 0;
    scramble_key_valid_i = 1'b1;
    scramble_key_i       = key;
    scramble_nonce_i     = nonce;
    next_cycle();
    scramble_key_valid_i = 1'b0;
    scramble_key_i       = '0;
    scramble_nonce_i     = '0;
    #5;
    while (scramble_req_o !== 1'b0) begin
      if (cycles >= ReqTimeout) begin
        abort_run("Timeout: scramble_req_o never fell after the key was supplied");
      end else begin
        next_cycle();
        #5;
        cycles++;
      end
    end
    next_cycle();
  endtask

  task automatic key_expect(input core_shell_pkg::scr_key_t key,
                            input core_shell_pkg::scr_nonce_t nonce,
                            input logic req, input logic valid);
    #5;
    check_key("scr_key_o", scr_key_o, key);
    check_nonce("scr_nonce_o", scr_nonce_o, nonce);
    check_bit("scramble_req_o", scramble_req_o, req);
    check_bit("scr_key_valid_o", scr_key_valid_o, valid);
    next_cycle();
  endtask

  task automatic require_fields(input int rc, input int want);
    if (rc != want) begin
      abort_run("Stimulus file line has the wrong number of fields");
    end
  endtask

  task automatic run_command(input int fd, input logic [7:0] cmd);
    int                         rc;
    int                         c;
    int                         hold;
    logic                       b, d, p, n, s0, s1;
    core_shell_pkg::reg_addr_t  ra, rb;
    core_shell_pkg::reg_data_t  da, db;
    core_shell_pkg::scr_key_t   key;
    core_shell_pkg::scr_nonce_t nonce;
    case (cmd)
      "#": begin
        c = $fgetc(fd);
        while (c != 10 && c != -1) c = $fgetc(fd);
      end
      "R": reset_check();
      "W": begin
        rc = $fscanf(fd, "%b %b %b %b %b %b", b, d, p, n, s0, s1);
        require_fields(rc, 6);
        set_wake(b, d, p, n, s0, s1);
      end
      "A": begin
        rc = $fscanf(fd, "%h %h", ra, da);
        require_fields(rc, 2);
        write_reg(ra, da);
      end
      "E": begin
        rc = $fscanf(fd, "%h %h %h %h", ra, da, rb, db);
        require_fields(rc, 4);
        read_expect(ra, da, rb, db);
      end
      "Q": begin
        rc = $fscanf(fd, "%d", hold);
        require_fields(rc, 1);
        key_request(hold);
      end
      "K": begin
        rc = $fscanf(fd, "%h %h", key, nonce);
        require_fields(rc, 2);
        key_supply(key, nonce);
      end
      "X": begin
        rc = $fscanf(fd, "%h %h %b %b", key, nonce, s0, s1);
        require_fields(rc, 4);
        key_expect(key, nonce, s0, s1);
      end
      default: abort_run($sformatf("Unknown command %c in stimulus file", cmd));
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int         fd;
    int         rc;
    logic [7:0] cmd;
    rst_ni               = 1'b0;
    test_en_i            = 1'b0;
    core_busy_i          = 1'b0;
    debug_req_i          = 1'b0;
    irq_pending_i        = 1'b0;
    irq_nm_i             = 1'b0;
    rf_raddr_a_i         = '0;
    rf_raddr_b_i         = '0;
    rf_waddr_i           = '0;
    rf_wdata_i           = '0;
    rf_we_i              = 1'b0;
    ic_scr_key_req_i     = 1'b0;
    scramble_key_valid_i = 1'b0;
    scramble_key_i       = '0;
    scramble_nonce_i     = '0;
    fd = $fopen(DataFile, "r");
    if (fd == 0) begin
      abort_run("Cannot open the stimulus file");
    end else begin
      repeat (4) @(posedge clk_i);
      #10;
      rst_ni = 1'b1;
      rc = $fscanf(fd, " %c", cmd);
      while (rc == 1) begin
        run_command(fd, cmd);
        rc = $fscanf(fd, " %c", cmd);
      end
      $fclose(fd);
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== verif/core_shell_asserts.sv ====
/*
 * Core shell assertions
 * Watches the key request outputs, the sleep flag and register zero
 */
module core_shell_asserts (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      debug_req_i,
  input logic                      irq_pending_i,
  input logic                      irq_nm_i,
  input logic                      core_sleep_o,
  input core_shell_pkg::reg_addr_t rf_raddr_a_i,
  input core_shell_pkg::reg_addr_t rf_raddr_b_i,
  input core_shell_pkg::reg_data_t rf_rdata_a_o,
  input core_shell_pkg::reg_data_t rf_rdata_b_o,
  input logic                      scramble_req_o,
  input logic                      scr_key_valid_o
);

  // Request and valid never overlap
  req_valid_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(scramble_req_o && scr_key_valid_o))
    else $error("scramble request and key valid overlap");

  sleep_needs_no_wake: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o |-> !(debug_req_i || irq_pending_i || irq_nm_i))
    else $error("core asleep while a wake input is high");

  // x0 on either port
  zero_reg_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rf_raddr_a_i == '0) |-> (rf_rdata_a_o == '0))
    else $error("register zero read nonzero on port a");

  zero_reg_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rf_raddr_b_i == '0) |-> (rf_rdata_b_o == '0))
    else $error("register zero read nonzero on port b");

endmodule

bind core_shell_top core_shell_asserts u_core_shell_asserts (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .debug_req_i    (debug_req_i),
  .irq_pending_i  (irq_pending_i),
  .irq_nm_i       (irq_nm_i),
  .core_sleep_o   (core_sleep_o),
  .rf_raddr_a_i   (rf_raddr_a_i),
  .rf_raddr_b_i   (rf_raddr_b_i),
  .rf_rdata_a_o   (rf_rdata_a_o),
  .rf_rdata_b_o   (rf_rdata_b_o),
  .scramble_req_o (scramble_req_o),
  .scr_key_valid_o(scr_key_valid_o)
);

// ==== hdl/core_shell_top.sv ====
/*
 * Core support shell
 * Sleep control with clock gate, gated register file and scramble key control
 */
module core_shell_top #(
  parameter bit                         Rv32e        = 1'b0,
  parameter core_shell_pkg::scr_key_t   RndCnstKey   = core_shell_pkg::RndCnstKeyDefault,
  parameter core_shell_pkg::scr_nonce_t RndCnstNonce = core_shell_pkg::RndCnstNonceDefault
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       test_en_i,

  // Sleep and wake
  input  logic                       core_busy_i,
  input  logic                       debug_req_i,
  input  logic                       irq_pending_i,
  input  logic                       irq_nm_i,
  output logic                       core_sleep_o,

  // Register file access
  input  core_shell_pkg::reg_addr_t  rf_raddr_a_i,
  input  core_shell_pkg::reg_addr_t  rf_raddr_b_i,
  output core_shell_pkg::reg_data_t  rf_rdata_a_o,
  output core_shell_pkg::reg_data_t  rf_rdata_b_o,
  input  core_shell_pkg::reg_addr_t  rf_waddr_i,
  input  core_shell_pkg::reg_data_t  rf_wdata_i,
  input  logic                       rf_we_i,

  // Scramble key provider
  input  logic                       ic_scr_key_req_i,
  input  logic                       scramble_key_valid_i,
  input  core_shell_pkg::scr_key_t   scramble_key_i,
  input  core_shell_pkg::scr_nonce_t scramble_nonce_i,
  output logic                       scramble_req_o,
  output logic                       scr_key_valid_o,
  output core_shell_pkg::scr_key_t   scr_key_o,
  output core_shell_pkg::scr_nonce_t scr_nonce_o
);

  // Core clock after the sleep gate
  logic clk_gated;

  ////////////////////////////////////////////////////////////
  // Sleep control
  ////////////////////////////////////////////////////////////

  core_sleep_ctrl u_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .test_en_i    (test_en_i),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .core_sleep_o (core_sleep_o),
    .clk_gated_o  (clk_gated)
  );

  ////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////

  core_regfile_ff #(
    .Rv32e(Rv32e)
  ) u_regfile (
    .clk_i    (clk_gated),
    .rst_ni   (rst_ni),
    .raddr_a_i(rf_raddr_a_i),
    .raddr_b_i(rf_raddr_b_i),
    .rdata_a_o(rf_rdata_a_o),
    .rdata_b_o(rf_rdata_b_o),
    .waddr_i  (rf_waddr_i),
    .wdata_i  (rf_wdata_i),
    .we_i     (rf_we_i)
  );

  ////////////////////////////////////////////////////////////
  // Scramble key control
  ////////////////////////////////////////////////////////////

  // Runs on the free clock so key updates arrive while the core sleeps
  scramble_key_ctrl #(
    .RndCnstKey  (RndCnstKey),
    .RndCnstNonce(RndCnstNonce)
  ) u_scramble_key_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .ic_scr_key_req_i    (ic_scr_key_req_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .scr_key_valid_o     (scr_key_valid_o),
    .scr_key_o           (scr_key_o),
    .scr_nonce_o         (scr_nonce_o)
  );

endmodule

// ==== hdl/core_regfile_ff.sv ====
/*
 * Flip-flop register file
 * Two combinational read ports, one write port, register zero reads as zero
 */
module core_regfile_ff #(
  parameter bit Rv32e = 1'b0
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  core_shell_pkg::reg_addr_t raddr_a_i,
  input  core_shell_pkg::reg_addr_t raddr_b_i,
  output core_shell_pkg::reg_data_t rdata_a_o,
  output core_shell_pkg::reg_data_t rdata_b_o,
  input  core_shell_pkg::reg_addr_t waddr_i,
  input  core_shell_pkg::reg_data_t wdata_i,
  input  logic                      we_i
);

  // RV32E keeps only the lower half of the register space
  localparam int unsigned NumRegs   = Rv32e ? 16 : 32;
  localparam int unsigned AddrUsedW = Rv32e ? 4 : 5;

  core_shell_pkg::reg_data_t rf_reg [NumRegs];
  logic [NumRegs-1:1]        we_dec;

  ////////////////////////////////////////////////////////////
  // Write decode and storage
  ////////////////////////////////////////////////////////////

  for (genvar i = 1; i < NumRegs; i++) begin : gen_regs
    assign we_dec[i] = we_i & (waddr_i[AddrUsedW-1:0] == AddrUsedW'(i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_reg[i] <= '0;
      end else if (we_dec[i]) begin
        rf_reg[i] <= wdata_i;
      end
    end
  end

  // x0 is hard-wired
  assign rf_reg[0] = '0;

  ////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////

  assign rdata_a_o = rf_reg[raddr_a_i[AddrUsedW-1:0]];
  assign rdata_b_o = rf_reg[raddr_b_i[AddrUsedW-1:0]];

endmodule

// ==== hdl/scramble_key_ctrl.sv ====
/*
 * Scramble key controller
 * Requests a fresh key from the key provider on an instruction cache request
 * and holds the current key and nonce
 */
module scramble_key_ctrl #(
  parameter core_shell_pkg::scr_key_t   RndCnstKey   = core_shell_pkg::RndCnstKeyDefault,
  parameter core_shell_pkg::scr_nonce_t RndCnstNonce = core_shell_pkg::RndCnstNonceDefault
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       ic_scr_key_req_i,
  input  logic                       scramble_key_valid_i,
  input  core_shell_pkg::scr_key_t   scramble_key_i,
  input  core_shell_pkg::scr_nonce_t scramble_nonce_i,
  output logic                       scramble_req_o,
  output logic                       scr_key_valid_o,
  output core_shell_pkg::scr_key_t   scr_key_o,
  output core_shell_pkg::scr_nonce_t scr_nonce_o
);

  core_shell_pkg::key_state_e key_state_d;
  core_shell_pkg::key_state_e key_state_q;

  ////////////////////////////////////////////////////////////
  // Request FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    key_state_d = key_state_q;
    unique case (key_state_q)
      core_shell_pkg::KeyValid: begin
        if (ic_scr_key_req_i) begin
          key_state_d = core_shell_pkg::KeyRequest;
        end
      end
      core_shell_pkg::KeyRequest: begin
        // Wait for the provider, however long it takes
        if (scramble_key_valid_i) begin
          key_state_d = core_shell_pkg::KeyValid;
        end
      end
      default: key_state_d = core_shell_pkg::KeyValid;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_state_q <= core_shell_pkg::KeyValid;
    end else begin
      key_state_q <= key_state_d;
    end
  end

  assign scramble_req_o  = (key_state_q == core_shell_pkg::KeyRequest);
  assign scr_key_valid_o = (key_state_q == core_shell_pkg::KeyValid);

  // Key and nonce take every strobe, requested or not
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scr_key_o   <= RndCnstKey;
      scr_nonce_o <= RndCnstNonce;
    end else if (scramble_key_valid_i) begin
      scr_key_o   <= scramble_key_i;
      scr_nonce_o <= scramble_nonce_i;
    end
  end

endmodule

// ==== hdl/core_sleep_ctrl.sv ====
/*
 * Sleep controller
 * Registers the core busy flag, forms the wake condition and gates the core clock
 */
module core_sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic core_sleep_o,
  output logic clk_gated_o
);

  logic core_busy_q;
  logic wake;
  logic gate_en_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Any pending event keeps the core clocked
  assign wake         = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~wake;

  ////////////////////////////////////////////////////////////
  // Clock gate
  ////////////////////////////////////////////////////////////

  // Enable is captured in the low phase so the gated clock is glitch free
  always_latch begin
    if (!clk_i) begin
      gate_en_q <= wake | test_en_i;
    end
  end

  assign clk_gated_o = clk_i & gate_en_q;

endmodule

// ==== hdl/core_shell_pkg.sv ====
/*
 * Core shell package
 * Widths, vector types, reset scramble constants and key controller states
 */
package core_shell_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned RegAddrW  = 5;
  localparam int unsigned RegDataW  = 32;
  localparam int unsigned ScrKeyW   = 128;
  localparam int unsigned ScrNonceW = 64;

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  typedef logic [RegAddrW-1:0]  reg_addr_t;
  typedef logic [RegDataW-1:0]  reg_data_t;
  typedef logic [ScrKeyW-1:0]   scr_key_t;
  typedef logic [ScrNonceW-1:0] scr_nonce_t;

  // Key and nonce used until the first key arrives
  localparam scr_key_t   RndCnstKeyDefault   = 128'h0d6f_3a81_c2e4_97b5_5e10_8c7a_f3b2_4d69;
  localparam scr_nonce_t RndCnstNonceDefault = 64'hf7a3_196c_2be8_d054;

  // Scramble key controller states
  typedef enum logic {
    KeyValid,
    KeyRequest
  } key_state_e;

endpackage
